// File: design/frag_settings.svh
`ifndef FRAG_SETTINGS_SVH
`define FRAG_SETTINGS_SVH

// Number of reassembly slots
`define FRAG_SLOT_COUNT 2
// Entries per slot and the longest fragment in bytes
`define FRAG_FIFO_DEPTH 64
// Data byte plus start-of-fragment bit
`define FRAG_WORD_WIDTH 9
`define FRAG_ID_WIDTH 16
// Host register data width
`define FRAG_CFG_WIDTH 16

`endif

// File: design/frag_pkg.sv
`default_nettype none

package frag_pkg;

    ////////////////////////////////////////////////////
    // Slot and dispatcher phases
    ////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        SLOT_IDLE,
        SLOT_CAPTURE,
        SLOT_DRAIN
    } slot_state_t;

    // Drain side of the dispatcher
    typedef enum logic {
        DISPATCH_SEEK,
        DISPATCH_STREAM
    } dispatch_state_t;

    // Host register map
    typedef enum logic [1:0] {
        CFG_CTRL       = 2'd0,
        CFG_SLOT_MASK  = 2'd1,
        CFG_FRAG_COUNT = 2'd2
    } cfg_addr_t;

endpackage

`default_nettype wire

// File: design/frag_slot_if.sv
`timescale 1ns/100ps
`default_nettype none
`include "frag_settings.svh"

interface frag_slot_if;

    // Capture side, driven by the dispatcher
    logic [`FRAG_WORD_WIDTH-2:0] data;
    logic                        data_enable;
    logic                        data_last;
    logic [`FRAG_ID_WIDTH-1:0]   fragment_id;
    logic                        push_data_enable;

    // Status and drain side, driven by the slot
    logic                        ready;
    logic                        data_ready;
    logic [`FRAG_WORD_WIDTH-1:0] push_data;
    logic                        push_data_valid;
    logic [`FRAG_ID_WIDTH-1:0]   current_packet_id;

    modport dispatch (
        output data, data_enable, data_last, fragment_id, push_data_enable,
        input  ready, data_ready, push_data, push_data_valid, current_packet_id
    );

    modport slot (
        input  data, data_enable, data_last, fragment_id, push_data_enable,
        output ready, data_ready, push_data, push_data_valid, current_packet_id
    );

endinterface

`default_nettype wire

// File: design/frag_sync_fifo.sv
`timescale 1ns/100ps
`default_nettype none
`include "frag_settings.svh"

module frag_sync_fifo (
    input  wire                         clock,
    input  wire                         reset_n,
    input  wire                         write_enable,
    input  wire [`FRAG_WORD_WIDTH-1:0]  write_data,
    input  wire                         read_enable,
    output logic [`FRAG_WORD_WIDTH-1:0] read_data,
    output logic                        read_data_valid,
    output logic                        full,
    output logic                        empty
);

    localparam int DEPTH = `FRAG_FIFO_DEPTH;
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [`FRAG_WORD_WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]               write_ptr;
    logic [AW-1:0]               read_ptr;
    logic [AW:0]                 count;
    logic                        do_write;
    logic                        do_read;

    assign do_write = write_enable && !full;
    assign do_read  = read_enable && !empty;

    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[write_ptr] <= write_data;
        end
    end

    // Pointers wrap explicitly so the depth need not be a power of two
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            write_ptr <= '0;
            read_ptr  <= '0;
            count     <= '0;
        end else begin
            if (do_write) begin
                write_ptr <= (write_ptr == AW'(DEPTH - 1)) ? '0 : write_ptr + 1'b1;
            end
            if (do_read) begin
                read_ptr <= (read_ptr == AW'(DEPTH - 1)) ? '0 : read_ptr + 1'b1;
            end
            count <= count + (AW + 1)'(do_write) - (AW + 1)'(do_read);
        end
    end

    // Head word shows without a read request
    assign read_data       = mem[read_ptr];
    assign read_data_valid = !empty;
    assign full            = (count == (AW + 1)'(DEPTH));
    assign empty           = (count == '0);

    no_write_when_full: assert property (@(posedge clock) disable iff (!reset_n)
        write_enable |-> !full);
    no_read_when_empty: assert property (@(posedge clock) disable iff (!reset_n)
        read_enable |-> !empty);

endmodule

`default_nettype wire

// File: design/frag_slot.sv
`timescale 1ns/100ps
`default_nettype none
`include "frag_settings.svh"

module frag_slot (
    input  wire       clock,
    input  wire       reset_n,
    frag_slot_if.slot bus
);

    import frag_pkg::*;

    slot_state_t                 state;
    slot_state_t                 state_next;
    logic [`FRAG_WORD_WIDTH-1:0] buffer_data;
    logic [`FRAG_WORD_WIDTH-1:0] buffer_data_next;
    logic                        buffer_valid;
    logic                        buffer_valid_next;
    logic [`FRAG_ID_WIDTH-1:0]   packet_id_next;
    logic                        fifo_empty;

    frag_sync_fifo fragment_fifo (
        .clock           (clock),
        .reset_n         (reset_n),
        .write_enable    (buffer_valid),
        .write_data      (buffer_data),
        .read_enable     (bus.push_data_enable),
        .read_data       (bus.push_data),
        .read_data_valid (bus.push_data_valid),
        .full            (),
        .empty           (fifo_empty)
    );

    always_comb begin
        state_next        = state;
        packet_id_next    = bus.current_packet_id;
        buffer_data_next  = buffer_data;
        buffer_valid_next = 1'b0;

        case (state)
            SLOT_IDLE: begin
                // First byte carries the start bit
                if (bus.data_enable) begin
                    packet_id_next    = bus.fragment_id;
                    buffer_data_next  = {1'b1, bus.data};
                    buffer_valid_next = 1'b1;
                    state_next        = bus.data_last ? SLOT_DRAIN : SLOT_CAPTURE;
                end
            end
            SLOT_CAPTURE: begin
                if (bus.data_enable) begin
                    buffer_data_next  = {1'b0, bus.data};
                    buffer_valid_next = 1'b1;
                    if (bus.data_last) begin
                        state_next = SLOT_DRAIN;
                    end
                end
            end
            SLOT_DRAIN: begin
                // Last byte may still sit in the buffer register
                if (fifo_empty && !buffer_valid) begin
                    state_next = SLOT_IDLE;
                end
            end
            default: state_next = SLOT_IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state          <= SLOT_IDLE;
            buffer_valid   <= 1'b0;
            bus.ready      <= 1'b0;
            bus.data_ready <= 1'b0;
        end else begin
            state          <= state_next;
            buffer_valid   <= buffer_valid_next;
            bus.ready      <= (state_next == SLOT_IDLE);
            bus.data_ready <= (state_next == SLOT_DRAIN);
        end
    end

    always_ff @(posedge clock) begin
        buffer_data           <= buffer_data_next;
        bus.current_packet_id <= packet_id_next;
    end

    no_byte_while_draining: assert property (@(posedge clock) disable iff (!reset_n)
        bus.data_enable |-> (state != SLOT_DRAIN));

endmodule

`default_nettype wire

// File: design/frag_dispatch.sv
`timescale 1ns/100ps
`default_nettype none
`include "frag_settings.svh"

module frag_dispatch (
    input  wire                          clock,
    input  wire                          reset_n,
    input  wire  [`FRAG_WORD_WIDTH-2:0]  in_data,
    input  wire                          in_valid,
    input  wire                          in_last,
    input  wire  [`FRAG_ID_WIDTH-1:0]    in_fragment_id,
    input  wire                          out_ready,
    input  wire                          enable,
    input  wire  [`FRAG_SLOT_COUNT-1:0]  slot_mask,
    output logic                         in_ready,
    output logic [`FRAG_WORD_WIDTH-1:0]  out_data,
    output logic [`FRAG_ID_WIDTH-1:0]    out_fragment_id,
    output logic                         out_valid,
    output logic                         frag_done,
    frag_slot_if.dispatch                slots [`FRAG_SLOT_COUNT]
);

    import frag_pkg::*;

    localparam int N = `FRAG_SLOT_COUNT;
    localparam int PTR_W = (N > 1) ? $clog2(N) : 1;

    dispatch_state_t             state;
    logic [PTR_W-1:0]            write_ptr;
    logic [PTR_W-1:0]            write_ptr_next;
    logic [PTR_W-1:0]            read_ptr;
    logic                        in_fragment;
    logic                        byte_accept;
    logic                        write_advance;
    logic [N-1:0]                slot_ready;
    logic [N-1:0]                slot_data_ready;
    logic [N-1:0]                slot_valid;
    logic [`FRAG_WORD_WIDTH-1:0] slot_data [N];
    logic [`FRAG_ID_WIDTH-1:0]   slot_id [N];

    // Next masked slot after ptr in round-robin order
    function automatic logic [PTR_W-1:0] next_slot(input logic [PTR_W-1:0] ptr,
                                                   input logic [N-1:0] mask);
        logic [PTR_W-1:0] result;
        int               idx;
        result = ptr;
        for (int i = N; i >= 1; i--) begin
            idx = (int'(ptr) + i) % N;
            if (mask[idx]) begin
                result = idx[PTR_W-1:0];
            end
        end
        return result;
    endfunction

    for (genvar g = 0; g < N; g++) begin : g_slot
        assign slots[g].data             = in_data;
        assign slots[g].data_enable      = byte_accept && (write_ptr == PTR_W'(g));
        assign slots[g].data_last        = in_last;
        assign slots[g].fragment_id      = in_fragment_id;
        assign slots[g].push_data_enable = (state == DISPATCH_STREAM) &&
                                           (read_ptr == PTR_W'(g)) &&
                                           out_ready && slots[g].push_data_valid;
        assign slot_ready[g]      = slots[g].ready;
        assign slot_data_ready[g] = slots[g].data_ready;
        assign slot_valid[g]      = slots[g].push_data_valid;
        assign slot_data[g]       = slots[g].push_data;
        assign slot_id[g]         = slots[g].current_packet_id;
    end

    ////////////////////////////////////////////////////
    // Input side
    ////////////////////////////////////////////////////

    // in_ready matters only on a fragment's first byte
    assign byte_accept    = in_valid && (in_fragment || in_ready);
    assign write_advance  = (byte_accept && in_last) ||
                            (!in_fragment && !byte_accept && !slot_mask[write_ptr]);
    assign write_ptr_next = write_advance ? next_slot(write_ptr, slot_mask) : write_ptr;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            write_ptr   <= '0;
            in_fragment <= 1'b0;
            in_ready    <= 1'b0;
            frag_done   <= 1'b0;
        end else begin
            write_ptr <= write_ptr_next;
            frag_done <= byte_accept && in_last;
            if (byte_accept) begin
                in_fragment <= !in_last;
            end
            // A slot taking a byte this cycle leaves idle on the next edge
            in_ready <= enable && slot_mask[write_ptr_next] && slot_ready[write_ptr_next] &&
                        !(byte_accept && write_ptr_next == write_ptr);
        end
    end

    ////////////////////////////////////////////////////
    // Drain side
    ////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state    <= DISPATCH_SEEK;
            read_ptr <= '0;
        end else begin
            case (state)
                DISPATCH_SEEK: begin
                    if (slot_data_ready[read_ptr]) begin
                        state <= DISPATCH_STREAM;
                    end else if (!slot_mask[read_ptr] && slot_ready[read_ptr]) begin
                        read_ptr <= next_slot(read_ptr, slot_mask);
                    end
                end
                DISPATCH_STREAM: begin
                    // Slot back in idle once its FIFO is empty
                    if (!slot_data_ready[read_ptr]) begin
                        state    <= DISPATCH_SEEK;
                        read_ptr <= next_slot(read_ptr, slot_mask);
                    end
                end
                default: state <= DISPATCH_SEEK;
            endcase
        end
    end

    assign out_valid       = (state == DISPATCH_STREAM) && slot_valid[read_ptr];
    assign out_data        = slot_data[read_ptr];
    assign out_fragment_id = slot_id[read_ptr];

    start_only_when_ready: assert property (@(posedge clock) disable iff (!reset_n)
        (in_valid && !in_fragment) |-> in_ready);

endmodule

`default_nettype wire

// File: design/frag_config_regs.sv
`timescale 1ns/100ps
`default_nettype none
`include "frag_settings.svh"

module frag_config_regs (
    input  wire                          clock,
    input  wire                          reset_n,
    input  wire                          cfg_req,
    input  wire                          cfg_write,
    input  wire frag_pkg::cfg_addr_t     cfg_addr,
    input  wire  [`FRAG_CFG_WIDTH-1:0]   cfg_wdata,
    input  wire                          frag_done,
    output logic                         cfg_ack,
    output logic [`FRAG_CFG_WIDTH-1:0]   cfg_rdata,
    output logic                         enable,
    output logic [`FRAG_SLOT_COUNT-1:0]  slot_mask
);

    import frag_pkg::*;

    logic [`FRAG_CFG_WIDTH-1:0] frag_count;
    logic                       access;

    // Phase 2 of the handshake starts here
    assign access = cfg_req && !cfg_ack;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            cfg_ack    <= 1'b0;
            enable     <= 1'b0;
            slot_mask  <= '1;
            frag_count <= '0;
        end else begin
            if (access) begin
                cfg_ack <= 1'b1;
            end else if (!cfg_req) begin
                cfg_ack <= 1'b0;
            end
            if (access && cfg_write && cfg_addr == CFG_CTRL) begin
                enable <= cfg_wdata[0];
            end
            if (access && cfg_write && cfg_addr == CFG_SLOT_MASK) begin
                slot_mask <= cfg_wdata[`FRAG_SLOT_COUNT-1:0];
            end
            // A write to the count clears it
            if (access && cfg_write && cfg_addr == CFG_FRAG_COUNT) begin
                frag_count <= '0;
            end else if (frag_done) begin
                frag_count <= frag_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (access) begin
            case (cfg_addr)
                CFG_CTRL:       cfg_rdata <= `FRAG_CFG_WIDTH'(enable);
                CFG_SLOT_MASK:  cfg_rdata <= `FRAG_CFG_WIDTH'(slot_mask);
                CFG_FRAG_COUNT: cfg_rdata <= frag_count;
                default:        cfg_rdata <= '0;
            endcase
        end
    end

    ack_follows_req: assert property (@(posedge clock) disable iff (!reset_n)
        $rose(cfg_ack) |-> $past(cfg_req));

endmodule

`default_nettype wire

// File: design/frag_reassembly_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "frag_settings.svh"

module frag_reassembly_top (
    input  wire                          clock,
    input  wire                          reset_n,
    input  wire  [`FRAG_WORD_WIDTH-2:0]  in_data,
    input  wire                          in_valid,
    input  wire                          in_last,
    input  wire  [`FRAG_ID_WIDTH-1:0]    in_fragment_id,
    output wire                          in_ready,
    output wire  [`FRAG_WORD_WIDTH-1:0]  out_data,
    output wire  [`FRAG_ID_WIDTH-1:0]    out_fragment_id,
    output wire                          out_valid,
    input  wire                          out_ready,
    input  wire                          cfg_req,
    input  wire                          cfg_write,
    input  wire  [1:0]                   cfg_addr,
    input  wire  [`FRAG_CFG_WIDTH-1:0]   cfg_wdata,
    output wire  [`FRAG_CFG_WIDTH-1:0]   cfg_rdata,
    output wire                          cfg_ack
);

    import frag_pkg::*;

    wire                        enable;
    wire [`FRAG_SLOT_COUNT-1:0] slot_mask;
    wire                        frag_done;

    frag_slot_if slot_bus [`FRAG_SLOT_COUNT] ();

    frag_config_regs config_regs (
        .clock     (clock),
        .reset_n   (reset_n),
        .cfg_req   (cfg_req),
        .cfg_write (cfg_write),
        .cfg_addr  (cfg_addr_t'(cfg_addr)),
        .cfg_wdata (cfg_wdata),
        .frag_done (frag_done),
        .cfg_ack   (cfg_ack),
        .cfg_rdata (cfg_rdata),
        .enable    (enable),
        .slot_mask (slot_mask)
    );

    frag_dispatch dispatch (
        .clock           (clock),
        .reset_n         (reset_n),
        .in_data         (in_data),
        .in_valid        (in_valid),
        .in_last         (in_last),
        .in_fragment_id  (in_fragment_id),
        .out_ready       (out_ready),
        .enable          (enable),
        .slot_mask       (slot_mask),
        .in_ready        (in_ready),
        .out_data        (out_data),
        .out_fragment_id (out_fragment_id),
        .out_valid       (out_valid),
        .frag_done       (frag_done),
        .slots           (slot_bus)
    );

    for (genvar g = 0; g < `FRAG_SLOT_COUNT; g++) begin : g_slot
        frag_slot slot (
            .clock   (clock),
            .reset_n (reset_n),
            .bus     (slot_bus[g])
        );
    end

endmodule

`default_nettype wire

// File: test/frag_reassembly_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "frag_settings.svh"

module frag_reassembly_tb;

    import frag_pkg::*;

    localparam int CLOCK_PERIOD = 100;
    localparam logic [15:0] SEED = 16'd29346;
    localparam int TOTAL_FRAGS = 18;
    // Output ready can be low three cycles in four
    localparam int MAX_GAP = 16;
    localparam int WATCHDOG_CYCLES = TOTAL_FRAGS * `FRAG_FIFO_DEPTH * MAX_GAP + 2000;

    typedef struct packed {
        logic                        last;
        logic [`FRAG_ID_WIDTH-1:0]   id;
        logic [`FRAG_WORD_WIDTH-1:0] word;
    } ref_entry_t;

    logic                        clock;
    logic                        reset_n;
    logic [`FRAG_WORD_WIDTH-2:0] in_data;
    logic                        in_valid;
    logic                        in_last;
    logic [`FRAG_ID_WIDTH-1:0]   in_fragment_id;
    wire                         in_ready;
    wire  [`FRAG_WORD_WIDTH-1:0] out_data;
    wire  [`FRAG_ID_WIDTH-1:0]   out_fragment_id;
    wire                         out_valid;
    logic                        out_ready;
    logic                        cfg_req;
    logic                        cfg_write;
    logic [1:0]                  cfg_addr;
    logic [`FRAG_CFG_WIDTH-1:0]  cfg_wdata;
    wire  [`FRAG_CFG_WIDTH-1:0]  cfg_rdata;
    wire                         cfg_ack;

    ref_entry_t                  ref_q [$];
    logic [15:0]                 data_lfsr;
    logic [15:0]                 gap_lfsr;
    int                          ready_level;
    int                          masked_slots;
    logic                        disabled_known;
    int                          frags_started;
    int                          frags_finished;
    int                          frags_sent;
    logic                        sending;
    logic                        got_valid;
    logic [`FRAG_WORD_WIDTH-1:0] got_word;
    logic [`FRAG_ID_WIDTH-1:0]   got_id;
    logic                        want_present;
    logic [`FRAG_WORD_WIDTH-1:0] want_word;
    logic [`FRAG_ID_WIDTH-1:0]   want_id;

    frag_reassembly_top uut (
        .clock           (clock),
        .reset_n         (reset_n),
        .in_data         (in_data),
        .in_valid        (in_valid),
        .in_last         (in_last),
        .in_fragment_id  (in_fragment_id),
        .in_ready        (in_ready),
        .out_data        (out_data),
        .out_fragment_id (out_fragment_id),
        .out_valid       (out_valid),
        .out_ready       (out_ready),
        .cfg_req         (cfg_req),
        .cfg_write       (cfg_write),
        .cfg_addr        (cfg_addr),
        .cfg_wdata       (cfg_wdata),
        .cfg_rdata       (cfg_rdata),
        .cfg_ack         (cfg_ack)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    ////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    task automatic draw_bits(inout logic [15:0] state, input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++) begin
            state = lfsr_next(state);
            value = (value << 1) | int'(state[0]);
        end
    endtask

    task automatic report_mismatch(input string msg);
        $display("ERR %0t: %s", $time, msg);
        $display("Verification failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    // Four-phase host access that returns at a falling edge with cfg_ack low
    task automatic host_access(input logic write, input cfg_addr_t addr,
                               input logic [15:0] wdata, output logic [15:0] rdata);
        @(posedge clock);
        cfg_req   <= 1'b1;
        cfg_write <= write;
        cfg_addr  <= addr;
        cfg_wdata <= wdata;
        do @(negedge clock); while (!cfg_ack);
        rdata = cfg_rdata;
        @(posedge clock);
        cfg_req <= 1'b0;
        do @(negedge clock); while (cfg_ack);
    endtask

    task automatic host_write(input cfg_addr_t addr, input logic [15:0] wdata);
        logic [15:0] unused;
        host_access(1'b1, addr, wdata, unused);
    endtask

    task automatic check_register(input cfg_addr_t addr, input int expected, input string what);
        logic [15:0] rdata;
        host_access(1'b0, addr, '0, rdata);
        assert (int'(rdata) == expected)
            else report_mismatch($sformatf("%s read %0d, expected %0d", what, rdata, expected));
    endtask

    task automatic send_fragment(input logic [15:0] id, input int length);
        int         value;
        ref_entry_t entry;
        // First byte only once the DUT shows in_ready
        do @(negedge clock); while (!in_ready);
        for (int i = 0; i < length; i++) begin
            draw_bits(data_lfsr, 8, value);
            entry.last = (i == length - 1);
            entry.id   = id;
            entry.word = {i == 0, value[7:0]};
            ref_q.push_back(entry);
            @(posedge clock);
            in_valid       <= 1'b1;
            in_data        <= value[7:0];
            in_last        <= (i == length - 1);
            in_fragment_id <= id;
        end
        @(posedge clock);
        in_valid <= 1'b0;
        in_last  <= 1'b0;
        frags_sent++;
    endtask

    task automatic send_random_fragments(input logic [15:0] first_id, input int count);
        int value;
        for (int n = 0; n < count; n++) begin
            draw_bits(data_lfsr, 6, value);
            send_fragment(first_id + 16'(n), value + 1);
        end
    endtask

    task automatic wait_drained();
        do @(negedge clock); while (ref_q.size() != 0);
        repeat (4) @(negedge clock);
        assert (!out_valid)
            else abort_run("out_valid still high after every expected word came out");
    endtask

    ////////////////////////////////////////////////////
    // Monitors and checks
    ////////////////////////////////////////////////////

    always @(posedge clock) begin
        int bits;
        if (ready_level >= 4) begin
            out_ready <= 1'b1;
        end else begin
            draw_bits(gap_lfsr, 2, bits);
            out_ready <= (bits < ready_level);
        end
    end

    // Counts fragment starts on the input
    always @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            sending       <= 1'b0;
            frags_started <= 0;
        end else if (in_valid) begin
            if (!sending) begin
                frags_started <= frags_started + 1;
            end
            sending <= !in_last;
        end
    end

    // Captures each accepted word with the reference entry it should match
    always @(posedge clock or negedge reset_n) begin
        ref_entry_t entry;
        if (!reset_n) begin
            got_valid      <= 1'b0;
            want_present   <= 1'b0;
            frags_finished <= 0;
        end else begin
            got_valid <= out_valid && out_ready;
            if (out_valid && out_ready) begin
                got_word     <= out_data;
                got_id       <= out_fragment_id;
                want_present <= (ref_q.size() > 0);
                if (ref_q.size() > 0) begin
                    entry = ref_q.pop_front();
                    want_word <= entry.word;
                    want_id   <= entry.id;
                    if (entry.last) begin
                        frags_finished <= frags_finished + 1;
                    end
                end
            end
        end
    end

    word_matches_reference: assert property (@(posedge clock) disable iff (!reset_n)
        got_valid |-> (want_present && got_word == want_word && got_id == want_id))
        else report_mismatch($sformatf("output word %h id %h, expected word %h id %h",
                             $sampled(got_word), $sampled(got_id),
                             $sampled(want_word), $sampled(want_id)));

    busy_slots_block_input: assert property (@(posedge clock) disable iff (!reset_n)
        ((frags_started - frags_finished) >= masked_slots) |-> !in_ready)
        else abort_run("in_ready was high while every enabled slot held a fragment");

    disabled_blocks_input: assert property (@(posedge clock) disable iff (!reset_n)
        disabled_known |-> !in_ready)
        else abort_run("in_ready was high while the block was disabled");

    ack_rises_after_req: assert property (@(posedge clock) disable iff (!reset_n)
        (cfg_req && !cfg_ack) |=> cfg_ack)
        else abort_run("cfg_ack did not rise one cycle after cfg_req");

    ack_falls_after_req: assert property (@(posedge clock) disable iff (!reset_n)
        (!cfg_req && cfg_ack) |=> !cfg_ack)
        else abort_run("cfg_ack did not fall one cycle after cfg_req dropped");

    initial begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        abort_run("Watchdog expired before the tests completed");
    end

    ////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////

    initial begin
        reset_n        = 1'b0;
        in_data        = '0;
        in_valid       = 1'b0;
        in_last        = 1'b0;
        in_fragment_id = '0;
        out_ready      = 1'b0;
        cfg_req        = 1'b0;
        cfg_write      = 1'b0;
        cfg_addr       = '0;
        cfg_wdata      = '0;
        data_lfsr      = SEED;
        gap_lfsr       = SEED;
        ready_level    = 4;
        masked_slots   = `FRAG_SLOT_COUNT;
        disabled_known = 1'b1;
        frags_sent     = 0;

        repeat (4) @(posedge clock);
        reset_n <= 1'b1;
        @(negedge clock);
        assert (!in_ready && !out_valid && !cfg_ack)
            else report_mismatch("handshake outputs not low after reset");

        // Single fragment
        disabled_known = 1'b0;
        host_write(CFG_CTRL, 16'd1);
        send_random_fragments(16'h0100, 1);
        wait_drained();

        // Back to back over both slots
        send_random_fragments(16'h0200, 6);
        wait_drained();
        check_register(CFG_FRAG_COUNT, frags_sent, "frag_count");
        host_write(CFG_FRAG_COUNT, 16'd0);
        frags_sent = 0;

        // Output back-pressure
        ready_level = 1;
        send_random_fragments(16'h0300, 8);
        wait_drained();
        ready_level = 4;
        check_register(CFG_FRAG_COUNT, frags_sent, "frag_count");

        // Disabled, then a single slot
        host_write(CFG_CTRL, 16'd0);
        disabled_known = 1'b1;
        repeat (20) @(negedge clock);
        check_register(CFG_CTRL, 0, "ctrl");
        disabled_known = 1'b0;
        host_write(CFG_CTRL, 16'd1);
        host_write(CFG_SLOT_MASK, 16'd1);
        masked_slots = 1;
        check_register(CFG_SLOT_MASK, 1, "slot_mask");
        ready_level = 2;
        send_random_fragments(16'h0400, 3);
        wait_drained();
        check_register(CFG_FRAG_COUNT, frags_sent, "frag_count");

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: frag_reassembly.f
+incdir+design
design/frag_pkg.sv
design/frag_slot_if.sv
design/frag_sync_fifo.sv
design/frag_slot.sv
design/frag_dispatch.sv
design/frag_config_regs.sv
design/frag_reassembly_top.sv
test/frag_reassembly_tb.sv

// File: Makefile
VERILATOR   ?= verilator
TOP         := frag_reassembly_tb
FILELIST    := frag_reassembly.f
BUILD_FLAGS := --binary --timing --assert -j 0
LINT_FLAGS  := --lint-only --timing -Wall
OBJ_DIR     := obj_dir
PASS_TEXT   := Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
